/* branchPredictorTop.f */
+incdir+src
src/bpTypes.sv
src/phtBankRam.sv
src/phtUpdateQueue.sv
src/bimodalPredictor.sv
src/branchPredictorTop.sv
verif/branchPredictor_checker.sv
verif/bpScoreboard.sv
verif/bpTb.sv

/* run.sh */
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module bpTb \
    -f branchPredictorTop.f -o VbpTb

# The simulation status is taken from the log below
./obj_dir/VbpTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
echo "Simulation passed"

/* src/bimodalPredictor.sv */
/*
 * Bimodal direction predictor control
 * Read index generation, taken mask, saturating counter update,
 * bank conflict arbitration with the update queue and the reset walk
 */
`include "bp_macros.svh"

module bimodalPredictor import bpTypes::*; (
    input  logic           clock,
    input  logic           reset,
    // Fetch side
    input  logic [31:0]    predPc,
    input  logic           btbHit [`FETCH_WIDTH],
    output logic           predTaken [`FETCH_WIDTH],
    output phtCounter_t    predCounter [`FETCH_WIDTH],
    output logic           predReady,
    // Resolved branches
    input  logic           updValid [`UPDATE_WIDTH],
    input  logic [31:0]    updPc [`UPDATE_WIDTH],
    input  logic           updTaken [`UPDATE_WIDTH],
    input  logic           updIsIndirect [`UPDATE_WIDTH],
    input  phtCounter_t    updPrevCounter [`UPDATE_WIDTH],
    output logic           updReady,
    // Counter RAM
    output phtIndex_t      readAddr [`FETCH_WIDTH],
    input  phtCounter_t    readData [`FETCH_WIDTH],
    output logic           writeEnable [`UPDATE_WIDTH],
    output phtIndex_t      writeAddr [`UPDATE_WIDTH],
    output phtCounter_t    writeData [`UPDATE_WIDTH],
    // Update queue
    output logic           push,
    output phtQueueEntry_t pushEntry,
    output logic           pop,
    input  phtQueueEntry_t headEntry,
    input  logic           empty,
    input  logic           full
);
    localparam int InsnBits = $clog2(`INSN_BYTE_WIDTH);
    localparam int BankBits = $clog2(`PHT_BANK_NUM);
    localparam phtCounter_t CounterMax = '1;
    localparam phtCounter_t WeaklyTaken = phtCounter_t'(CounterMax / 2 + 1);

    initState_t initState;
    phtIndex_t walkIndex;
    // Set when the group now in readData was read after the walk
    logic readReady;
    logic slotTaken [`FETCH_WIDTH];
    counterOp_t updOp [`UPDATE_WIDTH];
    phtIndex_t updIndex [`UPDATE_WIDTH];
    phtCounter_t updNext [`UPDATE_WIDTH];

    function automatic phtIndex_t pcToIndex(input logic [31:0] pc);
        return pc[InsnBits +: `PHT_INDEX_WIDTH];
    endfunction

    function automatic logic sameBank(input phtIndex_t a, input phtIndex_t b);
        return a[BankBits-1:0] == b[BankBits-1:0];
    endfunction

    function automatic phtCounter_t nextCounter(input counterOp_t op, input phtCounter_t prev);
        phtCounter_t result;
        result = prev;
        if (op == OP_INC && prev != CounterMax) begin
            result = prev + 1'b1;
        end else if (op == OP_DEC && prev != '0) begin
            result = prev - 1'b1;
        end
        return result;
    endfunction

    // Initialization walk, one entry per cycle through write port 0
    always_ff @(posedge clock) begin
        if (reset) begin
            initState <= INIT_WALK;
            walkIndex <= '0;
        end else if (initState == INIT_WALK) begin
            walkIndex <= walkIndex + 1'b1;
            if (walkIndex == phtIndex_t'(`PHT_ENTRY_NUM - 1)) begin
                initState <= INIT_DONE;
            end
        end
    end

    assign predReady = (initState == INIT_DONE);
    assign updReady = !full;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            readAddr[i] = pcToIndex(predPc + 32'(i * `INSN_BYTE_WIDTH));
        end
    end

    // Top counter bit plus a BTB hit predicts taken; later slots are masked
    always_comb begin
        logic found;
        found = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slotTaken[i] = readData[i][`PHT_COUNTER_WIDTH-1] && btbHit[i] && !found;
            found = found || slotTaken[i];
        end
    end

    // Second stage: btbHit arrives one cycle after predPc
    always_ff @(posedge clock) begin
        if (reset) begin
            readReady <= 1'b0;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                predTaken[i] <= 1'b0;
            end
        end else begin
            readReady <= predReady;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                predTaken[i] <= readReady && slotTaken[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            predCounter[i] <= readData[i];
        end
    end

    // Indirect branches leave the counter alone
    always_comb begin
        for (int i = 0; i < `UPDATE_WIDTH; i++) begin
            updIndex[i] = pcToIndex(updPc[i]);
            if (!updValid[i] || updIsIndirect[i]) begin
                updOp[i] = OP_NONE;
            end else if (updTaken[i]) begin
                updOp[i] = OP_INC;
            end else begin
                updOp[i] = OP_DEC;
            end
            updNext[i] = nextCounter(updOp[i], updPrevCounter[i]);
        end
    end

    always_comb begin
        logic placed;
        logic clash;
        placed = 1'b0;
        clash = 1'b0;
        for (int i = 0; i < `UPDATE_WIDTH; i++) begin
            writeEnable[i] = predReady && (updOp[i] != OP_NONE);
            writeAddr[i] = updIndex[i];
            writeData[i] = updNext[i];
        end
        push = 1'b0;
        pop = 1'b0;
        pushEntry.index = updIndex[1];
        pushEntry.counter = updNext[1];

        // Port 1 yields its bank to port 0 and waits in the queue
        if (writeEnable[0] && writeEnable[1] && sameBank(updIndex[0], updIndex[1])) begin
            writeEnable[1] = 1'b0;
            push = !full;
        end

        // Queue head takes the first idle port whose bank is free
        if (predReady && !empty) begin
            for (int i = 0; i < `UPDATE_WIDTH; i++) begin
                if (!placed && !writeEnable[i]) begin
                    clash = 1'b0;
                    for (int j = 0; j < `UPDATE_WIDTH; j++) begin
                        if (j != i && writeEnable[j] && sameBank(headEntry.index, writeAddr[j])) begin
                            clash = 1'b1;
                        end
                    end
                    if (!clash) begin
                        writeEnable[i] = 1'b1;
                        writeAddr[i] = headEntry.index;
                        writeData[i] = headEntry.counter;
                        pop = 1'b1;
                        placed = 1'b1;
                    end
                end
            end
        end

        if (initState == INIT_WALK) begin
            writeEnable[0] = 1'b1;
            writeAddr[0] = walkIndex;
            writeData[0] = WeaklyTaken;
        end
    end

endmodule

/* src/bpTypes.sv */
/*
 * Shared types of the bimodal predictor
 * Index and counter types, init and counter-operation enums,
 * and the deferred write held in the update queue
 */
`include "bp_macros.svh"

package bpTypes;

    typedef logic [`PHT_INDEX_WIDTH-1:0] phtIndex_t;
    typedef logic [`PHT_COUNTER_WIDTH-1:0] phtCounter_t;

    // Walk writes every entry before predictions are trusted
    typedef enum logic {
        INIT_WALK,
        INIT_DONE
    } initState_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_INC,
        OP_DEC
    } counterOp_t;

    typedef struct packed {
        phtIndex_t   index;
        phtCounter_t counter;
    } phtQueueEntry_t;

endpackage

/* src/bp_macros.svh */
/*
 * Sizing macros for the bimodal branch predictor
 * Table geometry, port widths, update queue depth and instruction size
 */
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Pattern history table geometry
`define PHT_ENTRY_NUM 256
`define PHT_INDEX_WIDTH 8
`define PHT_COUNTER_WIDTH 2
`define PHT_BANK_NUM 2

// Slots looked up per fetch group and resolved branches per cycle
`define FETCH_WIDTH 2
`define UPDATE_WIDTH 2

// Deferred writes held after a bank conflict
`define PHT_QUEUE_DEPTH 4

`define INSN_BYTE_WIDTH 4

`endif

/* src/branchPredictorTop.sv */
/*
 * Bimodal branch predictor top level
 * Connects the predictor control, the banked counter RAM
 * and the deferred update queue
 */
`include "bp_macros.svh"

module branchPredictorTop import bpTypes::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] predPc,
    input  logic        btbHit [`FETCH_WIDTH],
    input  logic        updValid [`UPDATE_WIDTH],
    input  logic [31:0] updPc [`UPDATE_WIDTH],
    input  logic        updTaken [`UPDATE_WIDTH],
    input  logic        updIsIndirect [`UPDATE_WIDTH],
    input  phtCounter_t updPrevCounter [`UPDATE_WIDTH],
    output logic        predTaken [`FETCH_WIDTH],
    output phtCounter_t predCounter [`FETCH_WIDTH],
    output logic        predReady,
    output logic        updReady
);
    // RAM side
    phtIndex_t      readAddr [`FETCH_WIDTH];
    phtCounter_t    readData [`FETCH_WIDTH];
    logic           writeEnable [`UPDATE_WIDTH];
    phtIndex_t      writeAddr [`UPDATE_WIDTH];
    phtCounter_t    writeData [`UPDATE_WIDTH];

    // Queue side
    logic           push;
    phtQueueEntry_t pushEntry;
    logic           pop;
    phtQueueEntry_t headEntry;
    logic           empty;
    logic           full;

    bimodalPredictor u_predictor (
        .clock, .reset,
        .predPc, .btbHit, .predTaken, .predCounter, .predReady,
        .updValid, .updPc, .updTaken, .updIsIndirect, .updPrevCounter, .updReady,
        .readAddr, .readData, .writeEnable, .writeAddr, .writeData,
        .push, .pushEntry, .pop, .headEntry, .empty, .full
    );

    phtBankRam u_pht (
        .clock,
        .readAddr,
        .readData,
        .writeEnable,
        .writeAddr,
        .writeData
    );

    phtUpdateQueue u_queue (
        .clock,
        .reset,
        .push,
        .pushEntry,
        .pop,
        .headEntry,
        .empty,
        .full
    );

endmodule

/* src/phtBankRam.sv */
/*
 * Banked pattern history table storage
 * Low index bits pick the bank, each bank takes one write per cycle
 * Read ports are registered
 */
`include "bp_macros.svh"

module phtBankRam import bpTypes::*; (
    input  logic        clock,
    input  phtIndex_t   readAddr [`FETCH_WIDTH],
    output phtCounter_t readData [`FETCH_WIDTH],
    input  logic        writeEnable [`UPDATE_WIDTH],
    input  phtIndex_t   writeAddr [`UPDATE_WIDTH],
    input  phtCounter_t writeData [`UPDATE_WIDTH]
);
    localparam int BankBits = $clog2(`PHT_BANK_NUM);
    localparam int RowNum = `PHT_ENTRY_NUM / `PHT_BANK_NUM;

    // One row array per bank
    phtCounter_t bankMem [`PHT_BANK_NUM][RowNum];

    function automatic logic [BankBits-1:0] bankOf(input phtIndex_t index);
        return index[BankBits-1:0];
    endfunction

    function automatic logic [`PHT_INDEX_WIDTH-BankBits-1:0] rowOf(input phtIndex_t index);
        return index[`PHT_INDEX_WIDTH-1:BankBits];
    endfunction

    // The arbiter upstream keeps every port on its own bank
    always_ff @(posedge clock) begin
        for (int p = 0; p < `UPDATE_WIDTH; p++) begin
            if (writeEnable[p]) begin
                bankMem[bankOf(writeAddr[p])][rowOf(writeAddr[p])] <= writeData[p];
            end
        end
    end

    // Consecutive slots differ in the low index bit, so each read
    // lands in a different bank
    always_ff @(posedge clock) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            readData[i] <= bankMem[bankOf(readAddr[i])][rowOf(readAddr[i])];
        end
    end

endmodule

/* src/phtUpdateQueue.sv */
/*
 * Update queue for counter writes deferred by a bank conflict
 * Circular storage with wrap-around head and tail pointers
 * and an occupancy count
 */
`include "bp_macros.svh"

module phtUpdateQueue import bpTypes::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           push,
    input  phtQueueEntry_t pushEntry,
    input  logic           pop,
    output phtQueueEntry_t headEntry,
    output logic           empty,
    output logic           full
);
    localparam int PtrBits = $clog2(`PHT_QUEUE_DEPTH);
    localparam int CountBits = $clog2(`PHT_QUEUE_DEPTH + 1);

    phtQueueEntry_t entries [`PHT_QUEUE_DEPTH];
    logic [PtrBits-1:0] headPtr;
    logic [PtrBits-1:0] tailPtr;
    logic [CountBits-1:0] count;

    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(`PHT_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[tailPtr] <= pushEntry;
        end
    end

    assign headEntry = entries[headPtr];
    assign empty = (count == '0);
    assign full = (count == CountBits'(`PHT_QUEUE_DEPTH));

endmodule

/* verif/bpScoreboard.sv */
/*
 * Prediction scoreboard
 * Reference taken mask, one-cycle compare process and error counts
 */
`include "bp_macros.svh"

module bpScoreboard import bpTypes::*; (
    input  logic        clock,
    input  logic        predTaken [`FETCH_WIDTH],
    input  phtCounter_t predCounter [`FETCH_WIDTH],
    input  logic        checkEn,
    input  phtCounter_t expCnt [`FETCH_WIDTH],
    input  logic        expHit [`FETCH_WIDTH],
    input  int          checkTest,
    output int          errorCount,
    output int          checkCount
);
    logic pendEn;
    phtCounter_t pendCnt [`FETCH_WIDTH];
    logic pendHit [`FETCH_WIDTH];
    int pendTest;

    // First taken slot wins, a slot needs a BTB hit and a strong or weak taken counter
    function automatic logic [`FETCH_WIDTH-1:0] expectedTaken(input phtCounter_t cnt [`FETCH_WIDTH],
                                                              input logic hit [`FETCH_WIDTH]);
        logic [`FETCH_WIDTH-1:0] mask;
        logic seen;
        mask = '0;
        seen = 1'b0;
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            if (!seen && hit[s] && cnt[s] >= phtCounter_t'(2)) begin
                mask[s] = 1'b1;
                seen = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic string testName(input int id);
        case (id)
            1: return "init";
            2: return "saturation";
            3: return "slotMasking";
            4: return "bankConflict";
            5: return "indirect";
            default: return "mixedRandom";
        endcase
    endfunction

    initial begin
        errorCount = 0;
        checkCount = 0;
        pendEn = 1'b0;
    end

    // Request arrives with btbHit, outputs settle after the next edge
    always @(posedge clock) begin
        pendEn <= checkEn;
        pendCnt <= expCnt;
        pendHit <= expHit;
        pendTest <= checkTest;
    end

    always @(negedge clock) begin
        logic [`FETCH_WIDTH-1:0] mask;
        if (pendEn) begin
            mask = expectedTaken(pendCnt, pendHit);
            checkCount = checkCount + 1;
            for (int s = 0; s < `FETCH_WIDTH; s++) begin
                if (predCounter[s] !== pendCnt[s]) begin
                    errorCount = errorCount + 1;
                    $display("Fail %s slot %0d counter: expected %0d, actual %0d",
                             testName(pendTest), s, pendCnt[s], predCounter[s]);
                end
                if (predTaken[s] !== mask[s]) begin
                    errorCount = errorCount + 1;
                    $display("Fail %s slot %0d taken: expected %0d, actual %0d",
                             testName(pendTest), s, mask[s], predTaken[s]);
                end
            end
        end
    end

endmodule

/* verif/bpTb.sv */
/*
 * Testbench top for the bimodal branch predictor
 * Clock, reset, falling-edge stimulus, counter model and watchdog
 */
`include "bp_macros.svh"

module bpTb import bpTypes::*; ();
    localparam int InsnBits = $clog2(`INSN_BYTE_WIDTH);
    localparam int Drain = `PHT_QUEUE_DEPTH + 1;
    localparam int Sweep = `PHT_ENTRY_NUM / `FETCH_WIDTH + 2;
    // Rough cycle budget of each test
    localparam int InitCycles = 2 + `PHT_ENTRY_NUM + Sweep;
    localparam int SatCycles = 10 * (3 + Drain);
    localparam int MaskCycles = `PHT_ENTRY_NUM / 2 + Drain + 202;
    localparam int ConflictCycles = 16 * (6 + Drain + Sweep)
        + `PHT_QUEUE_DEPTH + 1 + Drain + Sweep;
    localparam int IndirectCycles = 20 + Drain + Sweep;
    localparam int MixedCycles = 12 * (4 + Drain + 32) + Sweep;
    localparam int TestCycles = InitCycles + SatCycles + MaskCycles + ConflictCycles
        + IndirectCycles + MixedCycles;

    logic clock;
    logic reset;
    logic [31:0] predPc;
    logic btbHit [`FETCH_WIDTH];
    logic updValid [`UPDATE_WIDTH];
    logic [31:0] updPc [`UPDATE_WIDTH];
    logic updTaken [`UPDATE_WIDTH];
    logic updIsIndirect [`UPDATE_WIDTH];
    phtCounter_t updPrevCounter [`UPDATE_WIDTH];
    logic predTaken [`FETCH_WIDTH];
    phtCounter_t predCounter [`FETCH_WIDTH];
    logic predReady;
    logic updReady;

    // Scoreboard request and the group waiting for its btbHit cycle
    logic checkEn;
    phtCounter_t expCnt [`FETCH_WIDTH];
    logic expHit [`FETCH_WIDTH];
    int checkTest;
    logic pendValid;
    phtCounter_t pendCnt [`FETCH_WIDTH];
    logic pendHit [`FETCH_WIDTH];
    int pendTest;
    int curTest;

    phtCounter_t model [`PHT_ENTRY_NUM];
    logic used [`PHT_ENTRY_NUM];
    int tbErrors;
    int sbErrors;
    int sbChecks;

    branchPredictorTop u_dut (.*);

    bpScoreboard u_scoreboard (
        .clock, .predTaken, .predCounter, .checkEn, .expCnt, .expHit, .checkTest,
        .errorCount(sbErrors), .checkCount(sbChecks)
    );

    bind bimodalPredictor branchPredictor_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(TestCycles * 10 + 10000);
        $display("Timeout: tests did not finish within %0d cycles", TestCycles + 1000);
        $display("Result: FAILED");
        $finish;
    end

    function automatic phtIndex_t indexOf(input logic [31:0] pc);
        return pc[InsnBits +: `PHT_INDEX_WIDTH];
    endfunction

    function automatic logic [31:0] pcOf(input phtIndex_t idx);
        return {22'($urandom), idx, 2'b00};
    endfunction

    function automatic phtCounter_t satNext(input phtCounter_t prev, input logic taken);
        if (taken) begin
            return (prev == 2'd3) ? prev : prev + 2'd1;
        end
        return (prev == 2'd0) ? prev : prev - 2'd1;
    endfunction

    // One falling edge releases the previous group's btbHit and check and issues a new PC
    task automatic advance(input logic doPred, input logic [31:0] pc, input logic [1:0] hits);
        @(negedge clock);
        checkEn = pendValid;
        checkTest = pendTest;
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            expCnt[s] = pendCnt[s];
            expHit[s] = pendHit[s];
            btbHit[s] = pendHit[s];
        end
        for (int p = 0; p < `UPDATE_WIDTH; p++) begin
            updValid[p] = 1'b0;
            updIsIndirect[p] = 1'b0;
        end
        predPc = pc;
        pendValid = doPred;
        pendTest = curTest;
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            pendCnt[s] = model[indexOf(pc + 32'(s * `INSN_BYTE_WIDTH))];
            pendHit[s] = hits[s];
        end
    endtask

    task automatic idle(input int n);
        repeat (n) advance(1'b0, $urandom, 2'($urandom));
    endtask

    task automatic setUpdate(input int port, input phtIndex_t idx, input logic taken,
                             input logic indirect, input phtCounter_t prev);
        updValid[port] = 1'b1;
        updPc[port] = pcOf(idx);
        updTaken[port] = taken;
        updIsIndirect[port] = indirect;
        updPrevCounter[port] = prev;
        if (!indirect) begin
            model[idx] = satNext(prev, taken);
        end
    endtask

    task automatic clearUsed();
        for (int k = 0; k < `PHT_ENTRY_NUM; k++) begin
            used[k] = 1'b0;
        end
    endtask

    task automatic checkUpdReady(input logic expected);
        if (updReady !== expected) begin
            tbErrors++;
            $display("Fail bankConflict updReady: expected %0d, actual %0d",
                     expected, updReady);
        end
    endtask

    // Unused index of this burst, in the given bank unless bank is negative
    function automatic phtIndex_t pickFree(input int bank);
        phtIndex_t idx;
        do begin
            idx = phtIndex_t'($urandom);
            if (bank >= 0) begin
                idx[0] = bank[0];
            end
        end while (used[idx]);
        used[idx] = 1'b1;
        return idx;
    endfunction

    task automatic sweepTable();
        for (int g = 0; g < `PHT_ENTRY_NUM / `FETCH_WIDTH; g++) begin
            advance(1'b1, 32'(g * `FETCH_WIDTH * `INSN_BYTE_WIDTH), 2'($urandom));
        end
        idle(2);
    endtask

    task automatic updateBurst(input int cycles, input logic sameBank);
        int bank;
        phtIndex_t idx0;
        phtIndex_t idx1;
        clearUsed();
        for (int c = 0; c < cycles; c++) begin
            advance(1'b0, $urandom, 2'($urandom));
            if (updReady) begin
                bank = sameBank ? int'($urandom % 2) : -1;
                idx0 = pickFree(bank);
                idx1 = pickFree(bank);
                setUpdate(0, idx0, 1'($urandom), 1'b0, model[idx0]);
                setUpdate(1, idx1, 1'($urandom), 1'b0, model[idx1]);
            end
        end
        idle(Drain);
    endtask

    initial begin
        int cycles;
        phtCounter_t seen;
        phtIndex_t idx;
        void'($urandom(32'h72bf_3c9b));
        reset = 1'b1;
        predPc = '0;
        checkEn = 1'b0;
        checkTest = 0;
        pendValid = 1'b0;
        pendTest = 0;
        curTest = 1;
        tbErrors = 0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            btbHit[i] = 1'b1;
            expHit[i] = 1'b0;
            expCnt[i] = '0;
            pendHit[i] = 1'b0;
            pendCnt[i] = '0;
        end
        for (int p = 0; p < `UPDATE_WIDTH; p++) begin
            updValid[p] = 1'b0;
            updPc[p] = '0;
            updTaken[p] = 1'b0;
            updIsIndirect[p] = 1'b0;
            updPrevCounter[p] = '0;
        end
        for (int k = 0; k < `PHT_ENTRY_NUM; k++) begin
            model[k] = 2'd2;
            used[k] = 1'b0;
        end

        // Initialization walk timing
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        cycles = 0;
        while (!predReady && cycles < `PHT_ENTRY_NUM + 50) begin
            @(posedge clock);
            @(negedge clock);
            cycles++;
            if (predTaken[0] || predTaken[1]) begin
                tbErrors++;
                $display("Prediction reported taken before initialization finished");
            end
        end
        if (cycles != `PHT_ENTRY_NUM) begin
            tbErrors++;
            $display("Fail init predReady rise: expected %0d, actual %0d",
                     `PHT_ENTRY_NUM, cycles);
        end
        sweepTable();

        // Counter saturation on one PC, fed back from the DUT
        curTest = 2;
        idx = 8'h5c;
        for (int n = 0; n < 10; n++) begin
            advance(1'b1, pcOf(idx), 2'b11);
            idle(2);
            seen = predCounter[0];
            setUpdate(0, idx, n < 4, 1'b0, seen);
            idle(Drain);
        end
        advance(1'b1, pcOf(idx), 2'b11);
        idle(2);

        // Random table contents, then masking and btbHit gating
        curTest = 3;
        for (int r = 0; r < `PHT_ENTRY_NUM / 2; r++) begin
            advance(1'b0, $urandom, 2'($urandom));
            setUpdate(0, phtIndex_t'(2 * r), 1'($urandom), 1'b0, 2'($urandom));
            setUpdate(1, phtIndex_t'(2 * r + 1), 1'($urandom), 1'b0, 2'($urandom));
        end
        idle(Drain);
        repeat (200) advance(1'b1, {$urandom} & 32'hffff_fffc, 2'($urandom));
        idle(2);

        curTest = 4;
        // Pairs confined to bank 0 keep the head blocked, so the queue fills up
        clearUsed();
        for (int c = 0; c < `PHT_QUEUE_DEPTH; c++) begin
            advance(1'b0, $urandom, 2'($urandom));
            checkUpdReady(1'b1);
            idx = pickFree(0);
            setUpdate(0, idx, 1'($urandom), 1'b0, model[idx]);
            idx = pickFree(0);
            setUpdate(1, idx, 1'($urandom), 1'b0, model[idx]);
        end
        advance(1'b0, $urandom, 2'($urandom));
        checkUpdReady(1'b0);
        idle(Drain);
        checkUpdReady(1'b1);
        sweepTable();
        repeat (16) begin
            updateBurst(6, 1'b1);
            sweepTable();
        end

        // Indirect branches must leave every counter as it was
        curTest = 5;
        repeat (20) begin
            advance(1'b0, $urandom, 2'($urandom));
            setUpdate(0, phtIndex_t'($urandom), 1'($urandom), 1'b1, 2'($urandom));
            setUpdate(1, phtIndex_t'($urandom), 1'($urandom), 1'b1, 2'($urandom));
        end
        idle(Drain);
        sweepTable();

        curTest = 6;
        repeat (12) begin
            updateBurst(4, 1'b0);
            repeat (30) advance(1'b1, {$urandom} & 32'hffff_fffc, 2'($urandom));
            idle(2);
        end
        sweepTable();

        // The last scoreboard compare runs on the final falling edge
        @(posedge clock);
        $display("Checks: %0d, scoreboard errors: %0d, testbench errors: %0d",
                 sbChecks, sbErrors, tbErrors);
        if (sbErrors + tbErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verif/branchPredictor_checker.sv */
/*
 * Concurrent assertions bound into the predictor
 * Queue push and pop legality, bank-exclusive writes, predReady stability
 */
`include "bp_macros.svh"

module branchPredictor_checker import bpTypes::*; (
    input logic        clock,
    input logic        reset,
    input logic        push,
    input logic        pop,
    input logic        full,
    input logic        empty,
    input logic        predReady,
    input logic        writeEnable [`UPDATE_WIDTH],
    input phtIndex_t   writeAddr [`UPDATE_WIDTH],
    input logic        updValid [`UPDATE_WIDTH],
    input logic        updIsIndirect [`UPDATE_WIDTH],
    input logic [31:0] updPc [`UPDATE_WIDTH]
);
    localparam int InsnBits = $clog2(`INSN_BYTE_WIDTH);

    logic conflict;

    // Two counted updates aimed at one bank
    assign conflict = predReady && updValid[0] && updValid[1] && !updIsIndirect[0]
        && !updIsIndirect[1] && (updPc[0][InsnBits] == updPc[1][InsnBits]);

    pushWhileFull: assert property (@(posedge clock) disable iff (reset) !(push && full))
        else $error("queue push while full");

    popWhileEmpty: assert property (@(posedge clock) disable iff (reset) !(pop && empty))
        else $error("queue pop while empty");

    sameBankWrites: assert property (@(posedge clock) disable iff (reset)
        !(writeEnable[0] && writeEnable[1] && writeAddr[0][0] == writeAddr[1][0]))
        else $error("two RAM writes to one bank in a cycle");

    readyStable: assert property (@(posedge clock) disable iff (reset) predReady |=> predReady)
        else $error("predReady fell without reset");

    droppedUpdate: assert property (@(posedge clock) disable iff (reset) !(conflict && full))
        else $error("conflicting update dropped with a full queue");

endmodule
